//--- Makefile
VERILATOR   ?= verilator
TOP         := frontend_tb
FILELIST    := tb.f
FLAGS       := --binary --timing --assert
LINT_FLAGS  := --lint-only --timing
OBJ_DIR     := obj_dir
PASS_MSG    := NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- logic/branch_predecode.sv
module branch_predecode (
    input  logic               clk_i,
    input  logic               rst_ni,
    // address of the request issued this cycle
    input  fetch_pkg::addr_t   imem_addr_i,
    input  logic               imem_rvalid_i,
    input  fetch_pkg::instr_t  imem_rdata_i,
    input  logic               kill_i,
    // static prediction back to pc_gen
    output logic               pred_taken_o,
    output fetch_pkg::addr_t   pred_target_o,
    output logic               replay_o,
    output fetch_pkg::addr_t   replay_addr_o,
    fetch_entry_if.src         q
);
    import fetch_pkg::*;

    // pc of the outstanding request
    addr_t      resp_pc_q;
    logic [6:0] opcode;
    logic       is_jal;
    logic       is_branch;
    addr_t      jal_imm;
    addr_t      br_imm;
    addr_t      imm;
    logic       taken;
    addr_t      target;

    // --------------------------------------------------
    // response capture
    // --------------------------------------------------
    // memory answers one cycle after the request
    // so the address of last cycle is the pc of this response
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            resp_pc_q <= '0;
        end else begin
            resp_pc_q <= imem_addr_i;
        end
    end

    // --------------------------------------------------
    // branch scan
    // --------------------------------------------------
    assign opcode    = imem_rdata_i[6:0];
    assign is_jal    = (opcode == OPC_JAL);
    assign is_branch = (opcode == OPC_BRANCH);

    // j-type immediate, sign extended
    assign jal_imm = {{(XLEN-20){imem_rdata_i[31]}}, imem_rdata_i[19:12],
                      imem_rdata_i[20], imem_rdata_i[30:21], 1'b0};
    // b-type immediate, sign extended
    assign br_imm  = {{(XLEN-12){imem_rdata_i[31]}}, imem_rdata_i[7],
                      imem_rdata_i[30:25], imem_rdata_i[11:8], 1'b0};

    assign imm = is_jal ? jal_imm : br_imm;

    // jal always taken
    // conditional branch taken when the offset points backwards
    assign taken  = is_jal | (is_branch & br_imm[XLEN-1]);
    assign target = taken ? (resp_pc_q + imm) : (resp_pc_q + addr_t'(INSTR_BYTES));

    // --------------------------------------------------
    // push to the queue
    // --------------------------------------------------
    // a response in a redirect cycle is stale and discarded
    assign q.valid             = imem_rvalid_i & ~kill_i;
    assign q.entry.pc          = resp_pc_q;
    assign q.entry.instr       = imem_rdata_i;
    assign q.entry.pred_taken  = taken;
    assign q.entry.pred_target = target;

    // prediction only counts for an entry that actually goes in
    assign pred_taken_o  = q.valid & ~q.full & taken;
    assign pred_target_o = target;

    // queue full, refetch this pc once there is room
    // not gated by kill, pc_gen lets the later redirects win anyway
    assign replay_o      = imem_rvalid_i & q.full;
    assign replay_addr_o = resp_pc_q;

endmodule

//--- logic/fetch_entry_if.sv
// producer to queue link for predecoded fetch entries
interface fetch_entry_if;
    import fetch_pkg::*;

    // entry offered by predecode this cycle
    logic         valid;
    // payload of the offered entry
    fetch_entry_t entry;
    // queue has no free slot
    // an entry offered while full is dropped and replayed
    logic         full;

    // predecode side
    modport src (
        output valid,
        output entry,
        input  full
    );

    // queue side
    modport dst (
        input  valid,
        input  entry,
        output full
    );

endinterface

//--- logic/fetch_pkg.sv
package fetch_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    // address and instruction width of the core
    localparam int XLEN = 32;

    // byte step between two sequential fetches
    // one uncompressed instruction per fetch
    localparam int INSTR_BYTES = 4;

    // fetch queue sizing
    localparam int QUEUE_DEPTH = 4;
    // pointer width into the queue storage
    localparam int QUEUE_PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    // --------------------------------------------------
    // opcodes
    // --------------------------------------------------
    // major opcodes in instr[6:0] that predecode looks at
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // --------------------------------------------------
    // types
    // --------------------------------------------------
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [31:0]     instr_t;

    // one predecoded instruction on its way to the back end
    // pred_target holds the predicted next pc
    // which is pc + 4 when the instruction is not predicted taken
    typedef struct packed {
        addr_t  pc;
        instr_t instr;
        logic   pred_taken;
        addr_t  pred_target;
    } fetch_entry_t;

endpackage

//--- logic/fetch_queue.sv
module fetch_queue #(
    parameter type entry_t = fetch_pkg::fetch_entry_t
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    // drop everything buffered
    input  logic        flush_i,
    // back end side
    input  logic        ready_i,
    output logic        valid_o,
    output entry_t      data_o,
    // producer side
    fetch_entry_if.dst  q
);
    import fetch_pkg::*;

    // entry storage
    entry_t                 mem_q [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [QUEUE_PTR_W-1:0] rd_ptr_q;
    logic [QUEUE_PTR_W:0]   count_q;
    logic                   push;
    logic                   pop;

    // --------------------------------------------------
    // status
    // --------------------------------------------------
    assign q.full  = (count_q == (QUEUE_PTR_W + 1)'(QUEUE_DEPTH));
    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q];

    // an offered entry is written only when there is room
    assign push = q.valid & ~q.full & ~flush_i;
    assign pop  = valid_o & ready_i & ~flush_i;

    // --------------------------------------------------
    // pointers and count
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                // wrap at the last slot
                wr_ptr_q <= (wr_ptr_q == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop leave the count
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // write port
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= q.entry;
        end
    end

endmodule

//--- logic/frontend_top.sv
module frontend_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  fetch_pkg::addr_t        boot_addr_i,
    // instruction memory
    output logic                    imem_req_o,
    output fetch_pkg::addr_t        imem_addr_o,
    input  logic                    imem_rvalid_i,
    input  fetch_pkg::instr_t       imem_rdata_i,
    // back end control
    input  logic                    flush_i,
    input  logic                    resolve_mispredict_i,
    input  fetch_pkg::addr_t        resolve_target_i,
    input  logic                    eret_i,
    input  fetch_pkg::addr_t        epc_i,
    input  logic                    ex_valid_i,
    input  fetch_pkg::addr_t        trap_vector_base_i,
    input  logic                    set_pc_commit_i,
    input  fetch_pkg::addr_t        pc_commit_i,
    // to the back end
    output logic                    fetch_valid_o,
    output fetch_pkg::fetch_entry_t fetch_entry_o,
    input  logic                    fetch_ready_i
);
    import fetch_pkg::*;

    // --------------------------------------------------
    // internal wires
    // --------------------------------------------------
    logic  pred_taken;
    addr_t pred_target;
    logic  replay;
    addr_t replay_addr;
    logic  kill;

    // predecode to queue
    fetch_entry_if fetch_if ();

    pc_gen pc_gen_inst (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .boot_addr_i          (boot_addr_i),
        .pred_taken_i         (pred_taken),
        .pred_target_i        (pred_target),
        .replay_i             (replay),
        .replay_addr_i        (replay_addr),
        .queue_full_i         (fetch_if.full),
        .flush_i              (flush_i),
        .resolve_mispredict_i (resolve_mispredict_i),
        .resolve_target_i     (resolve_target_i),
        .eret_i               (eret_i),
        .epc_i                (epc_i),
        .ex_valid_i           (ex_valid_i),
        .trap_vector_base_i   (trap_vector_base_i),
        .set_pc_commit_i      (set_pc_commit_i),
        .pc_commit_i          (pc_commit_i),
        .imem_req_o           (imem_req_o),
        .imem_addr_o          (imem_addr_o),
        .kill_o               (kill)
    );

    branch_predecode branch_predecode_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .imem_addr_i   (imem_addr_o),
        .imem_rvalid_i (imem_rvalid_i),
        .imem_rdata_i  (imem_rdata_i),
        .kill_i        (kill),
        .pred_taken_o  (pred_taken),
        .pred_target_o (pred_target),
        .replay_o      (replay),
        .replay_addr_o (replay_addr),
        .q             (fetch_if.src)
    );

    fetch_queue #(
        .entry_t (fetch_entry_t)
    ) fetch_queue_inst (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .ready_i (fetch_ready_i),
        .valid_o (fetch_valid_o),
        .data_o  (fetch_entry_o),
        .q       (fetch_if.dst)
    );

endmodule

//--- logic/pc_gen.sv
module pc_gen (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  fetch_pkg::addr_t boot_addr_i,
    // static prediction from the response in flight
    input  logic             pred_taken_i,
    input  fetch_pkg::addr_t pred_target_i,
    // response dropped at a full queue
    input  logic             replay_i,
    input  fetch_pkg::addr_t replay_addr_i,
    input  logic             queue_full_i,
    // back end redirects
    input  logic             flush_i,
    input  logic             resolve_mispredict_i,
    input  fetch_pkg::addr_t resolve_target_i,
    input  logic             eret_i,
    input  fetch_pkg::addr_t epc_i,
    input  logic             ex_valid_i,
    input  fetch_pkg::addr_t trap_vector_base_i,
    input  logic             set_pc_commit_i,
    input  fetch_pkg::addr_t pc_commit_i,
    // memory request
    output logic             imem_req_o,
    output fetch_pkg::addr_t imem_addr_o,
    output logic             kill_o
);
    import fetch_pkg::*;

    // high in the first cycle after reset, selects boot_addr_i
    logic  rst_load_q;
    addr_t npc_d, npc_q;
    addr_t fetch_addr;

    // --------------------------------------------------
    // redirect and request
    // --------------------------------------------------
    // any redirect kills the response in flight
    // and holds off the request for this cycle
    assign kill_o = replay_i | resolve_mispredict_i | eret_i | ex_valid_i
                  | set_pc_commit_i | flush_i;

    assign imem_req_o  = ~queue_full_i & ~kill_o;
    assign imem_addr_o = fetch_addr;

    // --------------------------------------------------
    // next pc selection
    // --------------------------------------------------
    // later sources override earlier ones
    always_comb begin : npc_select
        fetch_addr = rst_load_q ? boot_addr_i : npc_q;
        // taken jal or backward branch just arrived, fetch its target now
        if (pred_taken_i) begin
            fetch_addr = pred_target_i;
        end
        // hold the address while no request goes out
        npc_d = fetch_addr;
        // sequential
        if (imem_req_o) begin
            npc_d = fetch_addr + addr_t'(INSTR_BYTES);
        end
        // refetch what the full queue could not take
        if (replay_i) begin
            npc_d = replay_addr_i;
        end
        if (resolve_mispredict_i) begin
            npc_d = resolve_target_i;
        end
        if (eret_i) begin
            npc_d = epc_i;
        end
        if (ex_valid_i) begin
            npc_d = trap_vector_base_i;
        end
        // restart behind the instruction in commit
        if (set_pc_commit_i) begin
            npc_d = pc_commit_i + addr_t'(INSTR_BYTES);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rst_load_q <= 1'b1;
            npc_q      <= '0;
        end else begin
            rst_load_q <= 1'b0;
            npc_q      <= npc_d;
        end
    end

endmodule

//--- tb.f
logic/fetch_pkg.sv
logic/fetch_entry_if.sv
logic/pc_gen.sv
logic/branch_predecode.sv
logic/fetch_queue.sv
logic/frontend_top.sv
test/frontend_asserts.sv
test/frontend_tb.sv

//--- test/frontend_asserts.sv
module frontend_asserts (
    input logic                            clk_i,
    input logic                            rst_ni,
    input logic                            flush_i,
    input logic                            fetch_valid_i,
    input logic                            imem_req_i,
    input logic                            queue_full_i,
    input logic [fetch_pkg::QUEUE_PTR_W:0]   queue_count_i,
    input logic [fetch_pkg::QUEUE_PTR_W-1:0] queue_wr_ptr_i
);
    import fetch_pkg::*;

    // --------------------------------------------------
    // reset
    // --------------------------------------------------
    // nothing is offered to the back end in reset
    valid_low_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !fetch_valid_i)
        else $error("fetch valid high during reset");

    // --------------------------------------------------
    // full queue
    // --------------------------------------------------
    // no new request while every slot holds an entry
    no_req_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (queue_count_i == (QUEUE_PTR_W + 1)'(QUEUE_DEPTH)) |-> !imem_req_i)
        else $error("memory request while queue full");

    // a full queue keeps its write pointer until a slot frees up
    no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        queue_full_i && !flush_i |=> $stable(queue_wr_ptr_i))
        else $error("queue written while full");

endmodule

bind frontend_top frontend_asserts frontend_asserts_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_o),
    .imem_req_i    (imem_req_o),
    .queue_full_i  (fetch_if.full),
    .queue_count_i (fetch_queue_inst.count_q),
    .queue_wr_ptr_i(fetch_queue_inst.wr_ptr_q)
);

//--- test/frontend_tb.sv
module frontend_tb;
    import fetch_pkg::*;

    localparam int MAX_CYCLES = 2000;

    logic clk_i = 1'b0;
    logic rst_ni, imem_req_o, imem_rvalid_i, flush_i, fetch_ready_i, fetch_valid_o;
    logic resolve_mispredict_i, eret_i, ex_valid_i, set_pc_commit_i;
    addr_t boot_addr_i, imem_addr_o, resolve_target_i, epc_i, trap_vector_base_i, pc_commit_i;
    instr_t imem_rdata_i;
    fetch_entry_t fetch_entry_o;

    // memory image plus a side table of what each word encodes
    instr_t mem [1024];
    int     kind [1024];
    int     offs [1024];
    logic   cap_req;
    addr_t  cap_addr;
    addr_t  model_pc;
    logic   checking = 1'b0;
    logic   rand_ready = 1'b0;
    int     accepted = 0;
    int     errors = 0;
    int     cycles = 0;
    int     tests_run = 0;

    frontend_top frontend_top_inst (.*);

    always #50 clk_i = ~clk_i;

    // --------------------------------------------------
    // memory model with one cycle latency
    // --------------------------------------------------
    always @(negedge clk_i) begin
        cap_req  = imem_req_o & rst_ni;
        cap_addr = imem_addr_o;
    end

    always @(posedge clk_i) begin
        #1;
        imem_rvalid_i = cap_req;
        imem_rdata_i  = mem[cap_addr[11:2]];
        if (rand_ready) begin
            fetch_ready_i = 1'($urandom % 2);
        end
    end

    // run limit
    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run went past %0d cycles without finishing", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // --------------------------------------------------
    // reference model and checker
    // --------------------------------------------------
    // an entry is taken at the edge after a cycle with valid and ready and no flush
    always @(negedge clk_i) begin
        logic       exp_taken;
        addr_t      exp_target;
        logic [9:0] idx;
        if (checking && fetch_valid_o && fetch_ready_i && !flush_i) begin
            idx        = model_pc[11:2];
            exp_taken  = (kind[idx] == 1) || (kind[idx] == 2 && offs[idx] < 0);
            exp_target = exp_taken ? model_pc + addr_t'(offs[idx]) : model_pc + 32'd4;
            if (fetch_entry_o.pc !== model_pc || fetch_entry_o.instr !== mem[idx]) begin
                $display("ERR %0t: pc %h instr %h, expected pc %h instr %h", $time,
                         fetch_entry_o.pc, fetch_entry_o.instr, model_pc, mem[idx]);
                errors++;
            end
            if (fetch_entry_o.pred_taken !== exp_taken
                || fetch_entry_o.pred_target !== exp_target) begin
                $display("ERR %0t: pc %h predicted %b -> %h, expected %b -> %h", $time,
                         model_pc, fetch_entry_o.pred_taken, fetch_entry_o.pred_target,
                         exp_taken, exp_target);
                errors++;
            end
            model_pc = exp_target;
            accepted++;
        end
    end

    // --------------------------------------------------
    // program building
    // --------------------------------------------------
    task automatic fill_memory();
        for (int i = 0; i < 1024; i++) begin
            // addi with an address dependent immediate so no word is a jump or branch
            mem[i]  = (((i * 32'h9e37_79b9) ^ (i << 13)) << 7) | 32'h13;
            kind[i] = 0;
            offs[i] = 0;
        end
    endtask

    task automatic place_jal(input addr_t a, input int off);
        logic [20:0] o;
        o = 21'(off);
        mem[a[11:2]]  = {o[20], o[10:1], o[11], o[19:12], 5'd0, OPC_JAL};
        kind[a[11:2]] = 1;
        offs[a[11:2]] = off;
    endtask

    task automatic place_branch(input addr_t a, input int off);
        logic [12:0] o;
        o = 13'(off);
        mem[a[11:2]]  = {o[12], o[10:5], 5'd2, 5'd1, 3'b000, o[4:1], o[11], OPC_BRANCH};
        kind[a[11:2]] = 2;
        offs[a[11:2]] = off;
    endtask

    // --------------------------------------------------
    // drive helpers
    // --------------------------------------------------
    task automatic reset_dut(input addr_t boot);
        checking    = 1'b0;
        rst_ni      = 1'b0;
        boot_addr_i = boot;
        model_pc    = boot;
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni   = 1'b1;
        checking = 1'b1;
    endtask

    task automatic wait_entries(input int n);
        int goal;
        goal = accepted + n;
        while (accepted < goal) begin
            @(posedge clk_i);
        end
        #1;
    endtask

    task automatic redirect(input logic mis, input logic er, input logic ex, input logic cm,
                            input addr_t next_pc);
        resolve_mispredict_i = mis;
        eret_i               = er;
        ex_valid_i           = ex;
        set_pc_commit_i      = cm;
        flush_i              = 1'b1;
        model_pc             = next_pc;
        @(posedge clk_i);
        #1;
        {resolve_mispredict_i, eret_i, ex_valid_i, set_pc_commit_i, flush_i} = '0;
        wait_entries(4);
    endtask

    task automatic report(input string name, input int err_before);
        tests_run++;
        $display("test %s done, %0d mismatches", name, errors - err_before);
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic test_sequential();
        int e;
        e = errors;
        fill_memory();
        reset_dut(32'h100);
        wait_entries(12);
        report("sequential", e);
    endtask

    task automatic test_prediction();
        int e;
        e = errors;
        fill_memory();
        place_branch(32'h204, 8);
        place_jal(32'h208, 32'h20);
        place_branch(32'h228, -16);
        reset_dut(32'h200);
        wait_entries(16);
        report("prediction", e);
    endtask

    task automatic test_redirects();
        int e;
        e = errors;
        fill_memory();
        reset_dut(32'h300);
        wait_entries(4);
        redirect(1'b1, 1'b0, 1'b0, 1'b0, resolve_target_i);
        redirect(1'b0, 1'b1, 1'b0, 1'b0, epc_i);
        redirect(1'b0, 1'b0, 1'b1, 1'b0, trap_vector_base_i);
        redirect(1'b0, 1'b0, 1'b0, 1'b1, pc_commit_i + 32'd4);
        // with several at once the later source in the precedence list wins
        redirect(1'b1, 1'b1, 1'b0, 1'b0, epc_i);
        redirect(1'b1, 1'b1, 1'b1, 1'b0, trap_vector_base_i);
        redirect(1'b1, 1'b1, 1'b1, 1'b1, pc_commit_i + 32'd4);
        report("redirects", e);
    endtask

    task automatic test_backpressure();
        int e;
        e = errors;
        fill_memory();
        place_jal(32'h610, 32'h40);
        place_branch(32'h660, -32);
        reset_dut(32'h600);
        fetch_ready_i = 1'b0;
        repeat (20) @(posedge clk_i);
        #1;
        rand_ready = 1'b1;
        wait_entries(24);
        rand_ready    = 1'b0;
        fetch_ready_i = 1'b1;
        report("backpressure", e);
    endtask

    task automatic test_flush();
        int e;
        e = errors;
        fill_memory();
        reset_dut(32'h700);
        fetch_ready_i = 1'b0;
        // let the queue fill with entries that must never show up
        // the request falls once it is full
        while (imem_req_o) begin
            @(posedge clk_i);
            #1;
        end
        pc_commit_i = 32'h7f0;
        set_pc_commit_i = 1'b1;
        flush_i         = 1'b1;
        model_pc        = 32'h7f4;
        @(posedge clk_i);
        #1;
        set_pc_commit_i = 1'b0;
        flush_i         = 1'b0;
        rand_ready      = 1'b1;
        wait_entries(8);
        rand_ready    = 1'b0;
        fetch_ready_i = 1'b1;
        report("flush", e);
    endtask

    initial begin
        void'($urandom(32'h8e5cd1f6));
        {rst_ni, imem_rvalid_i, flush_i, resolve_mispredict_i, eret_i} = '0;
        {ex_valid_i, set_pc_commit_i} = '0;
        fetch_ready_i      = 1'b1;
        imem_rdata_i       = '0;
        boot_addr_i        = '0;
        resolve_target_i   = 32'h400;
        epc_i              = 32'h480;
        trap_vector_base_i = 32'h500;
        pc_commit_i        = 32'h5f0;
        test_sequential();
        test_prediction();
        test_redirects();
        test_backpressure();
        test_flush();
        $display("%0d tests, %0d entries checked, %0d errors", tests_run, accepted, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
